// ==== include/ft_fifo_macros.svh ====
//**************************************************
// widths shared by the FTDI bridge and its FIFOs
// bank depth is 2**addr width, counts stay 24 bits
//**************************************************

`ifndef FT_FIFO_MACROS_SVH
`define FT_FIFO_MACROS_SVH

// one byte on the FTDI bus
`define FT_DATA_WIDTH     8

// ingress bank address, 16 entries per bank
`define FT_IN_ADDR_WIDTH  4

// egress bank address, 16 entries per bank
`define FT_OUT_ADDR_WIDTH 4

// bank size and occupancy counts
`define FT_COUNT_WIDTH    24

`endif

// ==== verilog/ft_fifo_pkg.sv ====
//**************************************************
// types for the FTDI 245 sync FIFO bridge
// active low pin fields keep the chip's polarity
//**************************************************

`include "ft_fifo_macros.svh"

package ft_fifo_pkg;

  typedef logic [`FT_DATA_WIDTH-1:0]  ft_byte_t;
  typedef logic [`FT_COUNT_WIDTH-1:0] fifo_count_t;

  // one bit per ping-pong bank
  typedef logic [1:0] bank_sel_t;

  // ingress word, flag set on the first byte of a chip burst
  typedef struct packed {
    logic     sof;
    ft_byte_t data;
  } in_word_t;

  // status pins from the chip
  typedef struct packed {
    logic rxf_n;
    logic txe_n;
  } ftdi_status_t;

  // strobes and output enable toward the chip
  typedef struct packed {
    logic rd_n;
    logic wr_n;
    logic oe_n;
  } ftdi_ctrl_t;

  typedef enum logic [1:0] {
    rd_idle,
    rd_wait_ftdi,
    rd_enable_output,
    rd_ftdi_read
  } read_state_t;

  typedef enum logic [1:0] {
    wr_idle,
    wr_fifo_ready,
    wr_send_to_ftdi
  } write_state_t;

endpackage

// ==== verilog/ppfifo.sv ====
//**************************************************
// two-bank ping-pong FIFO on one clock
// banks are read in commit order, one at a time
//**************************************************

`timescale 1ns/1ps

module ppfifo
  import ft_fifo_pkg::*;
#(
  parameter int DATA_WIDTH = 8,
  parameter int ADDR_WIDTH = 4
) (
  input  logic                  ftdi_clk,
  input  logic                  rst,
  // write side
  output bank_sel_t             write_ready,
  input  bank_sel_t             write_activate,
  output fifo_count_t           write_fifo_size,
  input  logic                  write_strobe,
  input  logic [DATA_WIDTH-1:0] write_data,
  output logic                  starved,
  // read side
  input  logic                  read_strobe,
  output logic                  read_ready,
  input  logic                  read_activate,
  output fifo_count_t           read_count,
  output logic [DATA_WIDTH-1:0] read_data
);

  localparam int DEPTH = 1 << ADDR_WIDTH;
  localparam fifo_count_t BANK_SIZE = fifo_count_t'(DEPTH);

  typedef enum logic [1:0] {
    bank_empty,
    bank_filling,
    bank_committed,
    bank_reading
  } bank_state_t;

  bank_state_t           bank_state [2];
  fifo_count_t           bank_count [2];
  logic [DATA_WIDTH-1:0] mem [2][DEPTH];
  logic                  head_bank;
  logic [ADDR_WIDTH:0]   rd_ptr;

  logic                  wr_bank;
  logic                  wr_en;
  logic                  rd_en;
  logic                  head_live;
  logic                  head_release;
  logic [1:0]            commit;
  logic [1:0]            busy_next;

  // lower bank wins if the filler holds both
  assign wr_bank = write_activate[0] ? 1'b0 : 1'b1;

  // a claimed bank accepts words on the same cycle the claim is seen
  assign wr_en = write_strobe && write_activate[wr_bank] &&
                 (bank_state[wr_bank] == bank_empty ||
                  bank_state[wr_bank] == bank_filling) &&
                 (bank_count[wr_bank] < BANK_SIZE);

  assign head_live = (bank_state[head_bank] == bank_committed) ||
                     (bank_state[head_bank] == bank_reading);

  assign rd_en = read_strobe && read_activate && head_live &&
                 (fifo_count_t'(rd_ptr) < bank_count[head_bank]);

  assign head_release = (bank_state[head_bank] == bank_reading) && !read_activate;

  // per bank commit and next-cycle occupancy
  always_comb begin
    for (int b = 0; b < 2; b++) begin
      commit[b] = (bank_state[b] == bank_filling) && !write_activate[b] &&
                  (bank_count[b] != '0);
      busy_next[b] = (bank_state[b] == bank_committed) ||
                     ((bank_state[b] == bank_reading) && !head_release);
    end
  end

  always_ff @(posedge ftdi_clk) begin
    if (rst) begin
      bank_state[0] <= bank_empty;
      bank_state[1] <= bank_empty;
      bank_count[0] <= '0;
      bank_count[1] <= '0;
      head_bank     <= 1'b0;
      rd_ptr        <= '0;
    end else begin
      for (int b = 0; b < 2; b++) begin
        case (bank_state[b])
          bank_empty: begin
            if (write_activate[b]) begin
              bank_state[b] <= bank_filling;
            end
          end
          bank_filling: begin
            // nothing written means the bank just goes back
            if (!write_activate[b]) begin
              bank_state[b] <= commit[b] ? bank_committed : bank_empty;
            end
          end
          bank_committed: begin
            if (read_activate && (head_bank == 1'(b))) begin
              bank_state[b] <= bank_reading;
            end
          end
          default: begin
            if (!read_activate) begin
              bank_state[b] <= bank_empty;
              bank_count[b] <= '0;
            end
          end
        endcase
      end

      if (wr_en) begin
        bank_count[wr_bank] <= bank_count[wr_bank] + fifo_count_t'(1);
      end

      if (head_release) begin
        rd_ptr <= '0;
      end else if (rd_en) begin
        rd_ptr <= rd_ptr + 1'b1;
      end

      // head moves to the older committed bank
      if (head_release && (bank_state[~head_bank] == bank_committed)) begin
        head_bank <= ~head_bank;
      end
      if (commit[0] && !busy_next[1]) begin
        head_bank <= 1'b0;
      end
      if (commit[1] && !busy_next[0]) begin
        head_bank <= 1'b1;
      end
    end
  end

  always_ff @(posedge ftdi_clk) begin
    if (wr_en) begin
      mem[wr_bank][bank_count[wr_bank][ADDR_WIDTH-1:0]] <= write_data;
    end
  end

  assign write_ready[0]  = (bank_state[0] == bank_empty);
  assign write_ready[1]  = (bank_state[1] == bank_empty);
  assign write_fifo_size = BANK_SIZE;
  assign starved         = !busy_next[0] && !busy_next[1] && !head_live;

  assign read_ready = (bank_state[head_bank] == bank_committed);
  assign read_count = bank_count[head_bank];
  assign read_data  = mem[head_bank][rd_ptr[ADDR_WIDTH-1:0]];

endmodule

// ==== verilog/ft_read_ctrl.sv ====
//**************************************************
// reads bursts from the chip into ingress banks
// waits for the write path to go idle before oe_n
//**************************************************

`timescale 1ns/1ps

module ft_read_ctrl
  import ft_fifo_pkg::*;
(
  input  logic         ftdi_clk,
  input  logic         rst,
  input  ftdi_status_t status,
  input  logic         write_busy,
  input  bank_sel_t    bank_ready,
  input  fifo_count_t  bank_size,
  input  ft_byte_t     data_in,
  output bank_sel_t    bank_activate,
  output logic         bank_strobe,
  output in_word_t     bank_word,
  output logic         rd_n,
  output logic         oe_n,
  output logic         read_busy
);

  read_state_t state;
  fifo_count_t room;
  logic        enable_reading;
  logic        prev_rxf_n;
  logic        sof;

  // chip advances its data on the same edge the byte is stored
  assign bank_strobe = (bank_activate != '0) && enable_reading &&
                       !status.rxf_n && (room != '0);
  assign rd_n        = ~bank_strobe;
  assign read_busy   = (state == rd_enable_output) || (state == rd_ftdi_read);
  assign bank_word   = '{sof: sof, data: data_in};

  // start of frame on the falling edge of rxf_n
  always_ff @(posedge ftdi_clk) begin
    if (rst) begin
      prev_rxf_n <= 1'b1;
      sof        <= 1'b0;
    end else begin
      if (prev_rxf_n && !status.rxf_n) begin
        sof <= 1'b1;
      end
      // first stored byte takes the flag
      if (bank_strobe) begin
        sof <= 1'b0;
      end
      prev_rxf_n <= status.rxf_n;
    end
  end

  always_ff @(posedge ftdi_clk) begin
    if (rst) begin
      state          <= rd_idle;
      bank_activate  <= '0;
      room           <= '0;
      enable_reading <= 1'b0;
      oe_n           <= 1'b1;
    end else begin
      enable_reading <= 1'b0;
      case (state)
        rd_idle: begin
          // lower free bank first
          if (bank_ready != '0) begin
            bank_activate <= bank_ready[0] ? 2'b01 : 2'b10;
            room          <= bank_size;
            state         <= rd_wait_ftdi;
          end
        end
        rd_wait_ftdi: begin
          if (!status.rxf_n && !write_busy) begin
            state <= rd_enable_output;
          end
        end
        rd_enable_output: begin
          oe_n  <= 1'b0;
          state <= rd_ftdi_read;
        end
        rd_ftdi_read: begin
          if ((room == '0) || status.rxf_n) begin
            // bank full or chip empty
            bank_activate <= '0;
            oe_n          <= 1'b1;
            state         <= rd_idle;
          end else begin
            enable_reading <= 1'b1;
            if (bank_strobe) begin
              room <= room - fifo_count_t'(1);
            end
          end
        end
        default: begin
          bank_activate <= '0;
          oe_n          <= 1'b1;
          state         <= rd_idle;
        end
      endcase
    end
  end

endmodule

// ==== verilog/ft_write_ctrl.sv ====
//**************************************************
// drains egress banks to the chip while txe_n low
// pauses whenever the read path owns the bus
//**************************************************

`timescale 1ns/1ps

module ft_write_ctrl
  import ft_fifo_pkg::*;
(
  input  logic         ftdi_clk,
  input  logic         rst,
  input  ftdi_status_t status,
  input  logic         read_busy,
  input  logic         bank_ready,
  input  fifo_count_t  bank_count,
  output logic         bank_activate,
  output logic         bank_strobe,
  output logic         wr_n,
  output logic         write_busy
);

  write_state_t state;
  fifo_count_t  remaining;

  // chip strobe and FIFO pop are one signal
  assign bank_strobe = (state == wr_send_to_ftdi) && !status.txe_n &&
                       (remaining != '0) && !read_busy;
  assign wr_n        = ~bank_strobe;
  assign write_busy  = (state != wr_idle);

  always_ff @(posedge ftdi_clk) begin
    if (rst) begin
      state         <= wr_idle;
      bank_activate <= 1'b0;
      remaining     <= '0;
    end else begin
      case (state)
        wr_idle: begin
          if (bank_ready) begin
            remaining     <= bank_count;
            bank_activate <= 1'b1;
            state         <= wr_fifo_ready;
          end
        end
        wr_fifo_ready: begin
          // head word settles while the bank is claimed
          state <= wr_send_to_ftdi;
        end
        wr_send_to_ftdi: begin
          if (remaining == '0) begin
            bank_activate <= 1'b0;
            state         <= wr_idle;
          end else if (bank_strobe) begin
            remaining <= remaining - fifo_count_t'(1);
          end
        end
        default: begin
          bank_activate <= 1'b0;
          state         <= wr_idle;
        end
      endcase
    end
  end

endmodule

// ==== verilog/ft_fifo_interface.sv ====
//**************************************************
// FTDI 245 sync FIFO bridge, all on ftdi_clk
// pad tristate lives outside, ftdi_data_oe drives it
//**************************************************

`timescale 1ns/1ps

`include "ft_fifo_macros.svh"

module ft_fifo_interface
  import ft_fifo_pkg::*;
(
  input  logic         ftdi_clk,
  input  logic         rst,
  // ingress, host side
  input  logic         in_fifo_read,
  output fifo_count_t  in_fifo_count,
  output logic         in_fifo_ready,
  input  logic         in_fifo_activate,
  output ft_byte_t     in_fifo_data,
  output logic         start_of_frame,
  // egress, host side
  input  logic         out_fifo_write,
  output fifo_count_t  out_fifo_write_size,
  output bank_sel_t    out_fifo_ready,
  input  bank_sel_t    out_fifo_activate,
  output logic         out_fifo_starved,
  input  ft_byte_t     out_fifo_data,
  // chip pins
  input  ftdi_status_t ftdi_status,
  output ftdi_ctrl_t   ftdi_ctrl,
  input  ft_byte_t     ftdi_data_in,
  output ft_byte_t     ftdi_data_out,
  output logic         ftdi_data_oe
);

  in_word_t    if_write_word;
  in_word_t    if_read_word;
  bank_sel_t   if_write_ready;
  bank_sel_t   if_write_activate;
  fifo_count_t if_write_fifo_size;
  logic        if_write_strobe;

  logic        of_read_ready;
  logic        of_read_activate;
  logic        of_read_strobe;
  fifo_count_t of_read_count;

  logic        read_busy;
  logic        write_busy;
  logic        rd_n;
  logic        wr_n;
  logic        oe_n;

  ppfifo #(
    .DATA_WIDTH ($bits(in_word_t)),
    .ADDR_WIDTH (`FT_IN_ADDR_WIDTH)
  ) fifo_in (
    .ftdi_clk        (ftdi_clk),
    .rst             (rst),
    .write_ready     (if_write_ready),
    .write_activate  (if_write_activate),
    .write_fifo_size (if_write_fifo_size),
    .write_strobe    (if_write_strobe),
    .write_data      (if_write_word),
    .starved         (),
    .read_strobe     (in_fifo_read),
    .read_ready      (in_fifo_ready),
    .read_activate   (in_fifo_activate),
    .read_count      (in_fifo_count),
    .read_data       (if_read_word)
  );

  // egress head byte sits on the bus until wr_n takes it
  ppfifo #(
    .DATA_WIDTH (`FT_DATA_WIDTH),
    .ADDR_WIDTH (`FT_OUT_ADDR_WIDTH)
  ) fifo_out (
    .ftdi_clk        (ftdi_clk),
    .rst             (rst),
    .write_ready     (out_fifo_ready),
    .write_activate  (out_fifo_activate),
    .write_fifo_size (out_fifo_write_size),
    .write_strobe    (out_fifo_write),
    .write_data      (out_fifo_data),
    .starved         (out_fifo_starved),
    .read_strobe     (of_read_strobe),
    .read_ready      (of_read_ready),
    .read_activate   (of_read_activate),
    .read_count      (of_read_count),
    .read_data       (ftdi_data_out)
  );

  ft_read_ctrl u_read_ctrl (
    .ftdi_clk      (ftdi_clk),
    .rst           (rst),
    .status        (ftdi_status),
    .write_busy    (write_busy),
    .bank_ready    (if_write_ready),
    .bank_size     (if_write_fifo_size),
    .data_in       (ftdi_data_in),
    .bank_activate (if_write_activate),
    .bank_strobe   (if_write_strobe),
    .bank_word     (if_write_word),
    .rd_n          (rd_n),
    .oe_n          (oe_n),
    .read_busy     (read_busy)
  );

  ft_write_ctrl u_write_ctrl (
    .ftdi_clk      (ftdi_clk),
    .rst           (rst),
    .status        (ftdi_status),
    .read_busy     (read_busy),
    .bank_ready    (of_read_ready),
    .bank_count    (of_read_count),
    .bank_activate (of_read_activate),
    .bank_strobe   (of_read_strobe),
    .wr_n          (wr_n),
    .write_busy    (write_busy)
  );

  assign in_fifo_data   = if_read_word.data;
  assign start_of_frame = if_read_word.sof;

  assign ftdi_ctrl = '{rd_n: rd_n, wr_n: wr_n, oe_n: oe_n};

  // fpga owns the bus whenever the chip's outputs are off
  assign ftdi_data_oe = oe_n;

endmodule

// ==== verif/ft_fifo_tb.sv ====
//**************************************************
// testbench for the FTDI bridge with chip and host models
// stops at the first mismatch, random seed is fixed
//**************************************************

`timescale 1ns/1ps

`include "ft_fifo_macros.svh"

module ft_fifo_tb
  import ft_fifo_pkg::*;
();

  localparam int CLK_PERIOD = 20;
  localparam int IN_DEPTH   = 1 << `FT_IN_ADDR_WIDTH;
  localparam int OUT_DEPTH  = 1 << `FT_OUT_ADDR_WIDTH;
  localparam int NUM_BURSTS = 12;
  localparam int TX_TOTAL   = 150;

  localparam ftdi_ctrl_t CTRL_IDLE  = '{rd_n: 1'b1, wr_n: 1'b1, oe_n: 1'b1};
  localparam ftdi_ctrl_t CTRL_READ  = '{rd_n: 1'b0, wr_n: 1'b1, oe_n: 1'b0};
  localparam ftdi_ctrl_t CTRL_WRITE = '{rd_n: 1'b1, wr_n: 1'b0, oe_n: 1'b1};

  logic         ftdi_clk;
  logic         rst;
  logic         in_fifo_read;
  fifo_count_t  in_fifo_count;
  logic         in_fifo_ready;
  logic         in_fifo_activate;
  ft_byte_t     in_fifo_data;
  logic         start_of_frame;
  logic         out_fifo_write;
  fifo_count_t  out_fifo_write_size;
  bank_sel_t    out_fifo_ready;
  bank_sel_t    out_fifo_activate;
  logic         out_fifo_starved;
  ft_byte_t     out_fifo_data;
  ftdi_status_t ftdi_status;
  ftdi_ctrl_t   ftdi_ctrl;
  ft_byte_t     ftdi_data_in;
  ft_byte_t     ftdi_data_out;
  logic         ftdi_data_oe;

  // stimulus, chip model state and progress counters
  ft_byte_t rx_data[$];
  int       burst_len[NUM_BURSTS];
  ft_byte_t tx_data[TX_TOTAL];
  ft_byte_t tx_got[$];
  int       chip_pos;
  int       burst_idx;
  int       burst_left;
  int       gap_left;
  int       rx_pos;
  int       tx_checked;
  bit       running;
  bit       stim_ready;
  longint   watchdog_ns;

  ft_fifo_interface dut (.*);

  always #(CLK_PERIOD / 2) ftdi_clk = ~ftdi_clk;

  // flag belongs to the first byte of each chip burst only
  function automatic bit expected_sof(int pos);
    int start;
    start = 0;
    for (int b = 0; b < NUM_BURSTS; b++) begin
      if (pos == start) begin
        return 1'b1;
      end
      start += burst_len[b];
    end
    return 1'b0;
  endfunction

  // a bank ends when it is full or when its chip burst ends
  function automatic int expected_bank_words(int pos);
    int start;
    int left;
    start = 0;
    left  = 0;
    for (int b = 0; b < NUM_BURSTS; b++) begin
      if (pos >= start && pos < start + burst_len[b]) begin
        left = start + burst_len[b] - pos;
      end
      start += burst_len[b];
    end
    return (left > IN_DEPTH) ? IN_DEPTH : left;
  endfunction

  // both directions keep their order
  function automatic ft_byte_t expected_rx_byte(int pos);
    return rx_data[pos];
  endfunction

  function automatic ft_byte_t expected_tx_byte(int idx);
    return tx_data[idx];
  endfunction

  task automatic abort_run(string reason);
    $display("%s", reason);
    $display("Simulation failed");
    $fatal(1);
  endtask

  task automatic check_byte(string name, ft_byte_t expected, ft_byte_t actual);
    if (actual !== expected) begin
      abort_run($sformatf("error %s expected %h actual %h", name, expected, actual));
    end
  endtask

  task automatic check_flag(string name, bit expected, logic actual);
    if (actual !== expected) begin
      abort_run($sformatf("error %s expected %b actual %b", name, expected, actual));
    end
  endtask

  task automatic check_ctrl(string name, ftdi_ctrl_t expected, ftdi_ctrl_t actual);
    if (actual !== expected) begin
      abort_run($sformatf("error %s expected %b actual %b", name, expected, actual));
    end
  endtask

  task automatic check_count(string name, fifo_count_t expected, fifo_count_t actual);
    if (actual !== expected) begin
      abort_run($sformatf("error %s expected %0d actual %0d", name, expected, actual));
    end
  endtask

  // chip side, strobes taken on the rising edge
  always @(posedge ftdi_clk) begin
    if (running) begin
      if (!ftdi_ctrl.rd_n && !ftdi_status.rxf_n) begin
        chip_pos++;
        burst_left--;
      end
      if (!ftdi_ctrl.wr_n && !ftdi_status.txe_n) begin
        tx_got.push_back(ftdi_data_out);
      end
    end
  end

  // chip side, status and data change on the falling edge
  always @(negedge ftdi_clk) begin
    if (running) begin
      ftdi_status.txe_n = (($urandom % 4) == 0);
      if (burst_left > 0) begin
        ftdi_status.rxf_n = 1'b0;
        ftdi_data_in      = rx_data[chip_pos];
      end else if (gap_left > 0) begin
        ftdi_status.rxf_n = 1'b1;
        gap_left--;
      end else if (burst_idx < NUM_BURSTS) begin
        burst_left        = burst_len[burst_idx];
        burst_idx++;
        gap_left          = 1 + int'($urandom % 3);
        ftdi_status.rxf_n = 1'b0;
        ftdi_data_in      = rx_data[chip_pos];
      end else begin
        ftdi_status.rxf_n = 1'b1;
      end
    end
  end

  // egress stream against the reference
  always @(negedge ftdi_clk) begin
    if (tx_got.size() > TX_TOTAL) begin
      abort_run("chip received more bytes than the host wrote");
    end
    while (tx_checked < tx_got.size()) begin
      check_byte($sformatf("egress byte %0d", tx_checked),
                 expected_tx_byte(tx_checked), tx_got[tx_checked]);
      tx_checked++;
    end
  end

  // only one owner of the bus at a time
  always @(posedge ftdi_clk) begin
    if (running) begin
      if (!ftdi_ctrl.rd_n) begin
        check_ctrl("control during chip read", CTRL_READ, ftdi_ctrl);
        check_flag("bus drive during chip read", 1'b0, ftdi_data_oe);
      end
      if (!ftdi_ctrl.wr_n) begin
        check_ctrl("control during chip write", CTRL_WRITE, ftdi_ctrl);
        check_flag("bus drive during chip write", 1'b1, ftdi_data_oe);
      end
    end
  end

  task automatic host_produce();
    int sent;
    int chunk;
    int b;
    sent = 0;
    while (sent < TX_TOTAL) begin
      @(negedge ftdi_clk);
      if (out_fifo_ready != '0) begin
        b = out_fifo_ready[0] ? 0 : 1;
        out_fifo_activate = bank_sel_t'(1 << b);
        check_count("egress bank size", fifo_count_t'(OUT_DEPTH), out_fifo_write_size);
        chunk = 1 + int'($urandom % OUT_DEPTH);
        if (chunk > TX_TOTAL - sent) begin
          chunk = TX_TOTAL - sent;
        end
        repeat (chunk) begin
          @(negedge ftdi_clk);
          out_fifo_write = 1'b1;
          out_fifo_data  = tx_data[sent];
          sent++;
        end
        // dropping the claim commits the bank
        @(negedge ftdi_clk);
        out_fifo_write    = 1'b0;
        out_fifo_activate = '0;
      end
    end
  endtask

  task automatic host_consume();
    int words;
    while (rx_pos < rx_data.size()) begin
      @(negedge ftdi_clk);
      if (in_fifo_ready) begin
        in_fifo_activate = 1'b1;
        @(negedge ftdi_clk);
        words = expected_bank_words(rx_pos);
        check_count($sformatf("ingress bank count at byte %0d", rx_pos),
                    fifo_count_t'(words), in_fifo_count);
        repeat (words) begin
          check_byte($sformatf("ingress byte %0d", rx_pos),
                     expected_rx_byte(rx_pos), in_fifo_data);
          check_flag($sformatf("start of frame at byte %0d", rx_pos),
                     expected_sof(rx_pos), start_of_frame);
          rx_pos++;
          in_fifo_read = 1'b1;
          @(negedge ftdi_clk);
        end
        in_fifo_read     = 1'b0;
        in_fifo_activate = 1'b0;
      end
    end
  endtask

  initial begin
    ftdi_clk          = 1'b0;
    rst               = 1'b1;
    in_fifo_read      = 1'b0;
    in_fifo_activate  = 1'b0;
    out_fifo_write    = 1'b0;
    out_fifo_activate = '0;
    out_fifo_data     = '0;
    ftdi_status       = '{rxf_n: 1'b1, txe_n: 1'b1};
    ftdi_data_in      = '0;
    chip_pos          = 0;
    burst_idx         = 0;
    burst_left        = 0;
    gap_left          = 0;
    rx_pos            = 0;
    tx_checked        = 0;
    running           = 1'b0;
    stim_ready        = 1'b0;

    void'($urandom(32'h5944));
    for (int b = 0; b < NUM_BURSTS; b++) begin
      burst_len[b] = 1 + int'($urandom % 40);
      repeat (burst_len[b]) begin
        rx_data.push_back(ft_byte_t'($urandom));
      end
    end
    for (int i = 0; i < TX_TOTAL; i++) begin
      tx_data[i] = ft_byte_t'($urandom);
    end
    // eight clocks per byte plus a fixed margin
    watchdog_ns = longint'(rx_data.size() + TX_TOTAL) * 8 * CLK_PERIOD + 2000;
    stim_ready  = 1'b1;

    // two reset cycles, then one idle cycle
    for (int i = 0; i < 3; i++) begin
      @(negedge ftdi_clk);
      check_ctrl($sformatf("control in start cycle %0d", i), CTRL_IDLE, ftdi_ctrl);
      check_flag($sformatf("ingress ready in start cycle %0d", i), 1'b0, in_fifo_ready);
      check_flag($sformatf("egress starved in start cycle %0d", i), 1'b1, out_fifo_starved);
      check_flag($sformatf("bus drive in start cycle %0d", i), 1'b1, ftdi_data_oe);
      if (i == 1) begin
        rst = 1'b0;
      end
    end
    running <= 1'b1;

    fork
      host_produce();
      host_consume();
    join
    wait (tx_checked == TX_TOTAL);
    // last egress bank goes back a couple of edges after its last byte
    for (int i = 0; i < 4 && !out_fifo_starved; i++) begin
      @(negedge ftdi_clk);
    end
    check_flag("egress starved after the last byte", 1'b1, out_fifo_starved);

    @(negedge ftdi_clk);
    check_flag("ingress ready after the last burst", 1'b0, in_fifo_ready);
    check_ctrl("control after both streams", CTRL_IDLE, ftdi_ctrl);
    $display("Simulation passed");
    $finish;
  end

  initial begin
    wait (stim_ready);
    #(watchdog_ns);
    $display("watchdog expired before both byte streams finished");
    $display("Simulation failed");
    $fatal(1);
  end

endmodule

// ==== filelist.f ====
+incdir+include
verilog/ft_fifo_pkg.sv
verilog/ppfifo.sv
verilog/ft_read_ctrl.sv
verilog/ft_write_ctrl.sv
verilog/ft_fifo_interface.sv
verif/ft_fifo_tb.sv

// ==== Makefile ====
# Verilator build and run for the FTDI bridge testbench

VERILATOR ?= verilator
TOP       ?= ft_fifo_tb
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal

SIM_BIN := $(BUILD_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST)) $(wildcard include/*.svh)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	@if grep -q "Simulation failed" $(LOG); then echo "run failed"; exit 1; fi
	@grep -q "Simulation passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
